/* blas_pkg.sv */
`default_nettype none

package blas_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int NUM_TILES	= 4;
	localparam int DATA_W		= 16;		// Operand and accumulator
	localparam int ISSUE_W		= 4;		// Issue numbers wrap mod 16

	// Commit buffer, entry picked by low bits of issue number
	localparam int COMMIT_DEPTH	= 4;
	localparam int PTR_W		= $clog2(COMMIT_DEPTH);
	localparam int CNT_W		= $clog2(COMMIT_DEPTH + 1);

	// Shift-add multiplier
	localparam int MUL_STEP		= 4;		// Bits per cycle
	localparam int MUL_CYCLES	= DATA_W / MUL_STEP;
	localparam int MUL_CNT_W	= $clog2(MUL_CYCLES);

	//////////////////////////////
	// Opcodes and states
	//////////////////////////////
	typedef enum logic [1:0] {
		OP_LOAD	= 2'd0,			// acc = operand
		OP_ADD	= 2'd1,			// acc = acc + operand
		OP_MUL	= 2'd2			// acc = acc * operand, multi-cycle
	} opcode_t;

	typedef enum logic {
		ISSUE_IDLE,
		ISSUE_HOLD				// Instruction held until issued
	} issue_state_t;

	typedef enum logic {
		TILE_IDLE,
		TILE_MUL_RUN
	} tile_state_t;

endpackage

`default_nettype wire

/* issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
	input	wire							clock,
	input	wire							arst_n,
	input	wire							req,			// Strobe from external side
	input	wire	blas_pkg::opcode_t		opcode,
	input	wire	[blas_pkg::DATA_W-1:0]	operand,
	input	wire	[blas_pkg::NUM_TILES-1:0]	tile_mask,
	input	wire	[blas_pkg::NUM_TILES-1:0]	tile_busy,
	input	wire							full,			// Commit buffer has no room
	output	logic							wait_flag,		// High while an instruction is held
	output	logic							issue_req,
	output	logic	[blas_pkg::ISSUE_W-1:0]	issue_no,
	output	blas_pkg::opcode_t				issue_opcode,
	output	logic	[blas_pkg::DATA_W-1:0]	issue_operand,
	output	logic	[blas_pkg::NUM_TILES-1:0]	issue_mask
);

	import blas_pkg::*;

	issue_state_t				state_q;
	logic						accept;
	logic						busy_hit;

	// Only masked tiles matter, others may keep running
	assign busy_hit		= |(tile_busy & issue_mask);

	assign accept		= (state_q == ISSUE_IDLE) && req;
	assign issue_req	= (state_q == ISSUE_HOLD) && !full && !busy_hit;
	assign wait_flag	= (state_q == ISSUE_HOLD);


	//////////////////////////////
	// State and issue counter
	//////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q		<= ISSUE_IDLE;
			issue_no	<= '0;
		end
		else begin
			case (state_q)
				ISSUE_IDLE: begin
					if (accept) begin
						state_q <= ISSUE_HOLD;
					end
				end
				ISSUE_HOLD: begin
					if (issue_req) begin
						state_q <= ISSUE_IDLE;
					end
				end
				default: begin
					state_q <= ISSUE_IDLE;
				end
			endcase

			if (issue_req) begin
				issue_no <= issue_no + ISSUE_W'(1);	// Wraps
			end
		end
	end


	// Held instruction, stays stable through HOLD
	always_ff @(posedge clock) begin
		if (accept) begin
			issue_opcode	<= opcode;
			issue_operand	<= operand;
			issue_mask		<= tile_mask;
		end
	end

endmodule

`default_nettype wire

/* commit_agg.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_agg (
	input	wire							clock,
	input	wire							arst_n,
	input	wire							issue_req,
	input	wire	[blas_pkg::ISSUE_W-1:0]	issue_no,
	input	wire	[blas_pkg::NUM_TILES-1:0]	issue_mask,
	input	wire	[blas_pkg::NUM_TILES-1:0]	term,			// Per-tile termination pulses
	input	wire	[blas_pkg::ISSUE_W-1:0]	term_no		[blas_pkg::NUM_TILES],
	output	logic							full,
	output	logic							commit_req,
	output	logic	[blas_pkg::ISSUE_W-1:0]	commit_no
);

	import blas_pkg::*;

	logic	[COMMIT_DEPTH-1:0]	valid_q;
	logic	[COMMIT_DEPTH-1:0]	valid_nxt;
	logic	[NUM_TILES-1:0]		pending_q	[COMMIT_DEPTH];	// Tiles still running
	logic	[NUM_TILES-1:0]		pending_nxt	[COMMIT_DEPTH];

	logic	[ISSUE_W-1:0]		head_no_q;		// Oldest outstanding number
	logic	[PTR_W-1:0]			head_ptr;
	logic	[PTR_W-1:0]			issue_ptr;
	logic	[CNT_W-1:0]			count_q;

	assign head_ptr		= head_no_q[PTR_W-1:0];
	assign issue_ptr	= issue_no[PTR_W-1:0];

	// Oldest entry done, so commit it
	assign commit_req	= valid_q[head_ptr] && (pending_q[head_ptr] == '0);
	assign commit_no	= head_no_q;
	assign full			= (count_q == CNT_W'(COMMIT_DEPTH));


	//////////////////////////////
	// Entry update
	//////////////////////////////
	always_comb begin
		pending_nxt	= pending_q;
		valid_nxt	= valid_q;

		// Terms may arrive out of order, each clears one bit
		for (int t = 0; t < NUM_TILES; t++) begin
			if (term[t]) begin
				pending_nxt[term_no[t][PTR_W-1:0]][t] = 1'b0;
			end
		end

		if (commit_req) begin
			valid_nxt[head_ptr] = 1'b0;
		end

		// Issue never hits a live entry since full blocks it
		if (issue_req) begin
			valid_nxt[issue_ptr]	= 1'b1;
			pending_nxt[issue_ptr]	= issue_mask;
		end
	end


	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			for (int e = 0; e < COMMIT_DEPTH; e++) begin
				pending_q[e] <= '0;
			end
		end
		else begin
			valid_q		<= valid_nxt;
			pending_q	<= pending_nxt;
		end
	end


	//////////////////////////////
	// Head pointer and occupancy
	//////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head_no_q	<= '0;
			count_q		<= '0;
		end
		else begin
			if (commit_req) begin
				head_no_q <= head_no_q + ISSUE_W'(1);
			end

			if (issue_req && !commit_req) begin
				count_q <= count_q + CNT_W'(1);
			end
			else if (!issue_req && commit_req) begin
				count_q <= count_q - CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* tile_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_exec (
	input	wire							clock,
	input	wire							arst_n,
	input	wire							issue_req,
	input	wire							issue_en,		// This tile's mask bit
	input	wire	[blas_pkg::ISSUE_W-1:0]	issue_no,
	input	wire	blas_pkg::opcode_t		issue_opcode,
	input	wire	[blas_pkg::DATA_W-1:0]	issue_operand,
	output	logic							busy,
	output	logic							term,
	output	logic	[blas_pkg::ISSUE_W-1:0]	term_no,
	output	logic	[blas_pkg::DATA_W-1:0]	acc
);

	import blas_pkg::*;

	tile_state_t				state_q;
	logic						start;
	logic						last_step;
	logic	[MUL_CNT_W-1:0]		step_q;

	logic	[DATA_W-1:0]		mcand_q;		// Shifted left each step
	logic	[DATA_W-1:0]		mplier_q;		// Shifted right each step
	logic	[DATA_W-1:0]		prod_q;
	logic	[DATA_W-1:0]		step_sum;

	assign start		= issue_req && issue_en && (state_q == TILE_IDLE);
	assign busy			= (state_q == TILE_MUL_RUN);
	assign last_step	= (step_q == MUL_CNT_W'(MUL_CYCLES - 1));

	// One shift-add step over MUL_STEP multiplier bits
	always_comb begin
		step_sum = prod_q;
		for (int b = 0; b < MUL_STEP; b++) begin
			if (mplier_q[b]) begin
				step_sum = step_sum + (mcand_q << b);
			end
		end
	end


	//////////////////////////////
	// Control and accumulator
	//////////////////////////////
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state_q	<= TILE_IDLE;
			step_q	<= '0;
			term	<= 1'b0;
			acc		<= '0;
		end
		else begin
			term <= 1'b0;
			case (state_q)
				TILE_IDLE: begin
					if (start) begin
						case (issue_opcode)
							OP_LOAD: begin
								acc		<= issue_operand;
								term	<= 1'b1;
							end
							OP_ADD: begin
								acc		<= acc + issue_operand;		// mod 2^16
								term	<= 1'b1;
							end
							OP_MUL: begin
								state_q	<= TILE_MUL_RUN;
								step_q	<= '0;
							end
							default: begin
								term	<= 1'b1;	// Unknown op, finish as no-op
							end
						endcase
					end
				end
				TILE_MUL_RUN: begin
					step_q <= step_q + MUL_CNT_W'(1);
					if (last_step) begin
						acc		<= step_sum;
						term	<= 1'b1;
						state_q	<= TILE_IDLE;
					end
				end
				default: begin
					state_q <= TILE_IDLE;
				end
			endcase
		end
	end


	// Multiplier operands and returned issue number
	always_ff @(posedge clock) begin
		if (start) begin
			term_no		<= issue_no;
			mcand_q		<= acc;
			mplier_q	<= issue_operand;
			prod_q		<= '0;
		end
		else if (busy) begin
			prod_q		<= step_sum;
			mcand_q		<= mcand_q << MUL_STEP;
			mplier_q	<= mplier_q >> MUL_STEP;
		end
	end

endmodule

`default_nettype wire

/* blas_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module blas_engine (
	input	wire							clock,
	input	wire							arst_n,
	input	wire							req,			// Request from external
	input	wire	blas_pkg::opcode_t		opcode,
	input	wire	[blas_pkg::DATA_W-1:0]	operand,
	input	wire	[blas_pkg::NUM_TILES-1:0]	tile_mask,
	output	logic							wait_flag,		// Hold off req while high
	output	logic							commit_req,
	output	logic	[blas_pkg::ISSUE_W-1:0]	commit_no,
	output	logic	[blas_pkg::DATA_W-1:0]	acc			[blas_pkg::NUM_TILES]
);

	import blas_pkg::*;

	logic						issue_req;
	logic	[ISSUE_W-1:0]		issue_no;
	opcode_t					issue_opcode;
	logic	[DATA_W-1:0]		issue_operand;
	logic	[NUM_TILES-1:0]		issue_mask;

	logic						full;

	logic	[NUM_TILES-1:0]		tile_busy;
	logic	[NUM_TILES-1:0]		tile_term;
	logic	[ISSUE_W-1:0]		tile_term_no	[NUM_TILES];


	issue_ctrl issue_ctrl (
		.clock(			clock			),
		.arst_n(		arst_n			),
		.req(			req				),
		.opcode(		opcode			),
		.operand(		operand			),
		.tile_mask(		tile_mask		),
		.tile_busy(		tile_busy		),
		.full(			full			),
		.wait_flag(		wait_flag		),
		.issue_req(		issue_req		),
		.issue_no(		issue_no		),
		.issue_opcode(	issue_opcode	),
		.issue_operand(	issue_operand	),
		.issue_mask(	issue_mask		)
	);


	commit_agg commit_agg (
		.clock(			clock			),
		.arst_n(		arst_n			),
		.issue_req(		issue_req		),
		.issue_no(		issue_no		),
		.issue_mask(	issue_mask		),
		.term(			tile_term		),
		.term_no(		tile_term_no	),
		.full(			full			),
		.commit_req(	commit_req		),
		.commit_no(		commit_no		)
	);


	// Broadcast issue, each tile picks its own mask bit
	for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
		tile_exec tile (
			.clock(			clock				),
			.arst_n(		arst_n				),
			.issue_req(		issue_req			),
			.issue_en(		issue_mask[i]		),
			.issue_no(		issue_no			),
			.issue_opcode(	issue_opcode		),
			.issue_operand(	issue_operand		),
			.busy(			tile_busy[i]		),
			.term(			tile_term[i]		),
			.term_no(		tile_term_no[i]		),
			.acc(			acc[i]				)
		);
	end

endmodule

`default_nettype wire

/* tb_blas_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_blas_engine;

	import blas_pkg::*;

	localparam int RESET_CYCLES		= 16;
	localparam int N_DIRECTED		= 4;
	localparam int N_RANDOM			= 300;
	localparam int N_BURST			= 16;
	localparam int TIMEOUT_CYCLES	= 200 * (N_DIRECTED + N_RANDOM + N_BURST);

	logic							clock = 1'b0;
	logic							arst_n;
	logic							req;
	opcode_t						opcode;
	logic	[DATA_W-1:0]			operand;
	logic	[NUM_TILES-1:0]			tile_mask;
	logic							wait_flag;
	logic							commit_req;
	logic	[ISSUE_W-1:0]			commit_no;
	logic	[DATA_W-1:0]			acc			[NUM_TILES];

	// Reference model and record of sent instructions
	logic	[DATA_W-1:0]			model_acc	[NUM_TILES];
	logic	[NUM_TILES-1:0]			sent_mask_q	[$];
	logic	[NUM_TILES*DATA_W-1:0]	sent_snap_q	[$];		// Expected acc of all tiles
	int								sent_count;
	int								commit_count = 0;
	int								cycle_count = 0;
	logic	[ISSUE_W-1:0]			expect_no = '0;
	logic							wait_seen;				// wait_flag taken at negedge
	logic							avoid_overlap;
	int								max_hold;
	string							test_name;

	logic	[31:0]					rng;
	opcode_t						rand_op;
	logic	[DATA_W-1:0]			rand_val;
	logic	[NUM_TILES-1:0]			rand_mask;

	blas_engine DUT (
		.clock(		clock		),
		.arst_n(	arst_n		),
		.req(		req			),
		.opcode(	opcode		),
		.operand(	operand		),
		.tile_mask(	tile_mask	),
		.wait_flag(	wait_flag	),
		.commit_req(commit_req	),
		.commit_no(	commit_no	),
		.acc(		acc			)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %0h actual %0h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// Tiles named by sent but not yet committed instructions
	function automatic logic [NUM_TILES-1:0] outstanding_tiles();
		logic [NUM_TILES-1:0] m;
		m = '0;
		for (int i = commit_count; i < sent_count; i++) begin
			m = m | sent_mask_q[i];
		end
		return m;
	endfunction

	task automatic send_instr(input opcode_t op, input logic [DATA_W-1:0] val,
			input logic [NUM_TILES-1:0] mask);
		logic [NUM_TILES*DATA_W-1:0] snap;
		int held;
		held = 0;
		@(posedge clock);
		while (wait_seen || (avoid_overlap && ((mask & outstanding_tiles()) != '0))) begin
			if (wait_seen) begin
				held++;
			end
			@(posedge clock);
		end
		if (held > max_hold) begin
			max_hold = held;
		end
		for (int t = 0; t < NUM_TILES; t++) begin
			if (mask[t]) begin
				case (op)
					OP_LOAD:	model_acc[t] = val;
					OP_ADD:		model_acc[t] = model_acc[t] + val;
					OP_MUL:		model_acc[t] = model_acc[t] * val;
					default:	model_acc[t] = model_acc[t];
				endcase
			end
			snap[t*DATA_W +: DATA_W] = model_acc[t];
		end
		sent_mask_q.push_back(mask);
		sent_snap_q.push_back(snap);
		sent_count = sent_count + 1;
		req			<= 1'b1;
		opcode		<= op;
		operand		<= val;
		tile_mask	<= mask;
		@(posedge clock);
		req			<= 1'b0;
	endtask

	task automatic drain_commits();
		while (commit_count < sent_count) begin
			@(posedge clock);
		end
		@(negedge clock);
	endtask

	//////////////////////////////
	// Commit monitor
	//////////////////////////////
	always @(negedge clock) begin
		wait_seen = wait_flag;
		if (arst_n && commit_req) begin
			if (commit_count >= sent_count) begin
				$display("Commit pulse seen with no instruction outstanding");
				$display("Some tests failed");
				$fatal(1);
			end
			else begin
				check_value({test_name, " commit_no"}, 32'(expect_no), 32'(commit_no));
				for (int t = 0; t < NUM_TILES; t++) begin
					if (sent_mask_q[commit_count][t]) begin
						check_value({test_name, " acc"},
							32'(sent_snap_q[commit_count][t*DATA_W +: DATA_W]), 32'(acc[t]));
					end
				end
				expect_no = expect_no + ISSUE_W'(1);	// Wraps mod 16
				commit_count = commit_count + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, %0d of %0d instructions committed",
				cycle_count, commit_count, sent_count);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		arst_n			= 1'b0;
		req				= 1'b0;
		opcode			= OP_LOAD;
		operand			= '0;
		tile_mask		= '0;
		rng				= 32'h9f94;
		sent_count		= 0;
		max_hold		= 0;
		avoid_overlap	= 1'b1;
		test_name		= "reset";
		for (int t = 0; t < NUM_TILES; t++) begin
			model_acc[t] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		check_value("reset wait", 32'd0, 32'(wait_flag));
		check_value("reset commit_req", 32'd0, 32'(commit_req));
		for (int t = 0; t < NUM_TILES; t++) begin
			check_value("reset acc", 32'd0, 32'(acc[t]));
		end

		test_name = "load_add";
		send_instr(OP_LOAD, 16'h1234, 4'b0001);
		send_instr(OP_ADD, 16'h0101, 4'b0001);
		send_instr(OP_LOAD, 16'hfff0, 4'b0100);
		send_instr(OP_ADD, 16'h0025, 4'b0100);		// Wraps past 2^16
		drain_commits();

		// Same-tile overlap would let a younger op change acc before the older commit
		test_name = "random_mix";
		repeat (N_RANDOM) begin
			rng = xorshift32(rng);
			case (rng % 3)
				0:			rand_op = OP_LOAD;
				1:			rand_op = OP_ADD;
				default:	rand_op = OP_MUL;
			endcase
			rand_val	= rng[23:8];
			rand_mask	= rng[27:24];
			send_instr(rand_op, rand_val, rand_mask);
		end
		drain_commits();

		// Back-to-back multiplies on tile 0 with some empty-mask instructions between
		test_name		= "burst";
		avoid_overlap	= 1'b0;
		max_hold		= 0;
		send_instr(OP_LOAD, 16'h0003, 4'b0001);
		for (int i = 0; i < N_BURST - 1; i++) begin
			rng = xorshift32(rng);
			if (i % 4 == 3) begin
				send_instr(OP_ADD, rng[15:0], 4'b0000);
			end
			else begin
				send_instr(OP_MUL, rng[15:0] | 16'h0001, 4'b0001);
			end
		end
		drain_commits();
		check_value("burst backpressure", 32'd1, 32'(max_hold > 1));

		test_name = "final";
		for (int t = 0; t < NUM_TILES; t++) begin
			check_value("final acc", 32'(model_acc[t]), 32'(acc[t]));
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
blas_pkg.sv
issue_ctrl.sv
commit_agg.sv
tile_exec.sv
blas_engine.sv
tb_blas_engine.sv

/* Makefile */
# Verilator build, run and lint for the BLAS issue and commit engine

VERILATOR	?= verilator
TOP			?= tb_blas_engine
LINT_TOP	?= $(TOP)
FILELIST	?= sources.f
BUILD_DIR	?= obj_dir
VFLAGS		?= --binary --timing -j 0
LINT_FLAGS	?= --lint-only --timing -Wall

SOURCES		:= $(shell cat $(FILELIST))
SIM_BIN		:= $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
